// ==== source/encCtrlPkg.sv ====
package encCtrlPkg;

	////////////////////////////////////////////////////////////////////////////
	// Frame geometry and table layout
	////////////////////////////////////////////////////////////////////////////

	localparam int frameLen          = 80;  // Samples per frame
	localparam int subfrLen          = 40;  // Samples per subframe
	localparam int framesPerAnalysis = 2;   // Arrivals before analysis starts
	localparam int numUnits          = 25;
	localparam int numSteps          = 46;
	localparam int loopTopStep       = 19;  // Subframe loop test
	localparam int predStep          = 35;  // Parity skip target

	////////////////////////////////////////////////////////////////////////////
	// Analysis units
	////////////////////////////////////////////////////////////////////////////

	typedef enum logic [4:0]
	{
		autocorr,
		lag,
		levinson,
		az,
		quaLsp,
		intLpc,
		intQlpc,
		math1,
		percVar,
		weightAz,
		residu,
		synFilt,
		pitchOl,
		math2,
		math3,
		pitchFr3,
		encLag3,
		parityPitch,
		predLt3,
		convolve,
		gPitch,
		testErr,
		math4,
		acelpCodebook,
		math5
	} unitId_t;

	typedef logic [numUnits-1:0] unitMask_t;  // Bit position is the unit id
	typedef logic [5:0] mathSel_t;             // Owner of the shared math unit
	typedef logic [6:0] subfr_t;               // First sample of the subframe
	typedef logic [5:0] stepIndex_t;

	////////////////////////////////////////////////////////////////////////////
	// Step descriptor
	////////////////////////////////////////////////////////////////////////////

	typedef enum logic [2:0]
	{
		runUnit,
		pause,
		loopTest,
		parityTest,
		loopInc,
		finish
	} stepKind_t;

	// Load strobes for the encoder parameter registers
	typedef struct packed
	{
		logic tOp;
		logic t0Bounds;    // T0_min and T0_max together
		logic filterAddr;  // A and Aq addresses together
		logic iGamma;
		logic t0;
		logic index;
		logic gainPit;
		logic temp;
		logic lTemp;
		logic pulseIdx;
		logic subfr;
	} paramLoad_t;

	typedef struct packed
	{
		stepKind_t  kind;
		unitId_t    unit;     // Only meaningful for runUnit
		mathSel_t   mathSel;
		paramLoad_t loads;
	} stepDesc_t;

endpackage

// ==== source/frameGate.sv ====
`timescale 1ns/1ps

module frameGate (
	input  logic clock,
	input  logic reset,
	input  logic armed,
	input  logic frameDone,
	output logic analysisReady
);
	import encCtrlPkg::*;

	logic [1:0] arrivals;
	logic [1:0] nextArrivals;

	assign nextArrivals = arrivals + {1'b0, frameDone};

	// Arrival counter stays at zero until the sequencer arms it
	always_ff @(posedge clock)
	begin
		if (reset || !armed)
		begin
			arrivals      <= '0;
			analysisReady <= 1'b0;
		end
		else if (nextArrivals == framesPerAnalysis)
		begin
			arrivals      <= '0;    // Start counting the next pair
			analysisReady <= 1'b1;
		end
		else
		begin
			arrivals      <= nextArrivals;
			analysisReady <= 1'b0;
		end
	end

endmodule

// ==== source/stepTable.sv ====
`timescale 1ns/1ps

module stepTable (
	input  encCtrlPkg::stepIndex_t stepIndex,
	output encCtrlPkg::stepDesc_t  step
);
	import encCtrlPkg::*;

	function automatic stepDesc_t runStep(unitId_t id, mathSel_t sel, paramLoad_t ld);
		return '{runUnit, id, sel, ld};
	endfunction

	// Control steps carry no unit
	function automatic stepDesc_t ctlStep(stepKind_t kind, mathSel_t sel, paramLoad_t ld);
		return '{kind, autocorr, sel, ld};
	endfunction

	always_comb
	begin
		case (stepIndex)
			////////////////////////////////////////////////////////////////////
			// LPC analysis and perceptual weighting once per frame
			////////////////////////////////////////////////////////////////////
			6'd0:  step = runStep(autocorr, 6'd0, '0);
			6'd1:  step = runStep(lag, 6'd1, '0);
			6'd2:  step = runStep(levinson, 6'd2, '0);
			6'd3:  step = runStep(az, 6'd3, '0);
			6'd4:  step = runStep(quaLsp, 6'd4, '0);
			6'd5:  step = runStep(intLpc, 6'd5, '0);
			6'd6:  step = runStep(intQlpc, 6'd6, '0);
			6'd7:  step = runStep(math1, 6'd7, '0);
			6'd8:  step = runStep(percVar, 6'd8, '0);
			6'd9:  step = runStep(weightAz, 6'd9, '0);
			6'd10: step = runStep(weightAz, 6'd10, '0);
			6'd11: step = runStep(residu, 6'd11, '0);
			6'd12: step = runStep(synFilt, 6'd12, '0);
			6'd13: step = runStep(weightAz, 6'd13, '0);
			6'd14: step = runStep(weightAz, 6'd14, '0);
			6'd15: step = runStep(residu, 6'd15, '0);
			6'd16: step = runStep(synFilt, 6'd16, '0);
			6'd17: step = runStep(pitchOl, 6'd17, '{tOp: 1'b1, default: 1'b0});
			6'd18: step = runStep(math2, 6'd18, '{t0Bounds: 1'b1, filterAddr: 1'b1, default: 1'b0});

			////////////////////////////////////////////////////////////////////
			// Subframe loop
			////////////////////////////////////////////////////////////////////
			6'd19: step = ctlStep(loopTest, 6'd19, '0);
			6'd20: step = runStep(weightAz, 6'd19, '0);
			6'd21: step = runStep(weightAz, 6'd20, '0);
			6'd22: step = runStep(math3, 6'd21, '{iGamma: 1'b1, default: 1'b0});
			6'd23: step = runStep(synFilt, 6'd22, '0);
			6'd24: step = runStep(synFilt, 6'd23, '0);
			6'd25: step = runStep(residu, 6'd24, '0);
			6'd26: step = runStep(synFilt, 6'd25, '0);
			6'd27: step = runStep(residu, 6'd26, '0);
			6'd28: step = runStep(synFilt, 6'd27, '0);
			6'd29: step = runStep(pitchFr3, 6'd28, '{t0: 1'b1, default: 1'b0});
			6'd30: step = runStep(encLag3, 6'd29, '{index: 1'b1, t0Bounds: 1'b1, default: 1'b0});
			6'd31: step = ctlStep(pause, 6'd30, '0);
			6'd32: step = ctlStep(parityTest, 6'd31, '0);  // Parity only in subframe 0
			6'd33: step = runStep(parityPitch, 6'd31, '0);
			6'd34: step = ctlStep(pause, 6'd32, '0);
			6'd35: step = runStep(predLt3, 6'd33, '0);
			6'd36: step = runStep(convolve, 6'd34, '0);
			6'd37: step = runStep(gPitch, 6'd35, '{gainPit: 1'b1, default: 1'b0});
			6'd38: step = runStep(testErr, 6'd36, '{temp: 1'b1, default: 1'b0});
			6'd39: step = runStep(math4, 6'd37, '{gainPit: 1'b1, lTemp: 1'b1, default: 1'b0});
			6'd40: step = runStep(acelpCodebook, 6'd38, '{index: 1'b1, pulseIdx: 1'b1, default: 1'b0});
			6'd41: step = ctlStep(pause, 6'd39, '0);
			6'd42: step = ctlStep(pause, 6'd40, '0);
			6'd43: step = runStep(math5, 6'd41, '{subfr: 1'b1, default: 1'b0});
			6'd44: step = ctlStep(loopInc, 6'd42, '{filterAddr: 1'b1, default: 1'b0});
			6'd45: step = ctlStep(finish, 6'd0, '0);
			default: step = ctlStep(finish, 6'd0, '0);  // Out of range ends the frame
		endcase
	end

endmodule

// ==== source/stepSequencer.sv ====
`timescale 1ns/1ps

module stepSequencer (
	input  logic                   clock,
	input  logic                   reset,
	input  logic                   start,
	input  logic                   divErr,
	input  logic                   analysisReady,
	input  encCtrlPkg::stepDesc_t  step,
	input  encCtrlPkg::unitMask_t  unitDone,
	output encCtrlPkg::stepIndex_t stepIndex,
	output logic                   armed,
	output encCtrlPkg::unitMask_t  unitStart,
	output encCtrlPkg::mathSel_t   mathSel,
	output encCtrlPkg::paramLoad_t paramLoad,
	output logic                   clearParams,
	output logic                   done,
	output encCtrlPkg::subfr_t     subframe
);
	import encCtrlPkg::*;

	typedef enum logic [1:0] {modeIdle, modeWait, modeRun} mode_t;

	mode_t      mode;
	logic       firstCycle;  // Start pulse goes out in this cycle
	logic       unitHit;     // Running unit reports done
	logic       stepEnd;
	stepIndex_t nextIndex;

	// A done in the start cycle belongs to an earlier step
	assign unitHit = !firstCycle && unitDone[step.unit];

	assign armed       = (mode != modeIdle);
	assign clearParams = (mode == modeIdle) && !start;

	////////////////////////////////////////////////////////////////////////////
	// Step completion and branch target
	////////////////////////////////////////////////////////////////////////////

	always_comb
	begin
		stepEnd   = 1'b1;
		nextIndex = stepIndex + 1'b1;
		case (step.kind)
			runUnit:
				stepEnd = unitHit;
			loopTest:
				nextIndex = (subframe < frameLen) ? stepIndex_t'(loopTopStep + 1)
					: stepIndex_t'(numSteps - 1);
			parityTest:
				if (subframe != '0)
					nextIndex = stepIndex_t'(predStep);  // Skip parity after subframe 0
			loopInc:
				nextIndex = stepIndex_t'(loopTopStep);
			default:
				;
		endcase
	end

	// Strobes toward the units and parameter registers
	always_comb
	begin
		unitStart = '0;
		mathSel   = '0;
		paramLoad = '0;
		done      = 1'b0;
		if (mode == modeRun)
		begin
			mathSel = step.mathSel;
			case (step.kind)
				runUnit:
				begin
					if (firstCycle)
						unitStart[step.unit] = 1'b1;
					if (unitHit)
						paramLoad = step.loads;
				end
				pause, loopInc:
					paramLoad = step.loads;
				finish:
					done = !divErr;  // Abort wins over completion
				default:
					;
			endcase
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Mode, step index and subframe counter
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			mode       <= modeIdle;
			stepIndex  <= '0;
			firstCycle <= 1'b0;
			subframe   <= '0;
		end
		else if (divErr)
		begin
			mode     <= modeIdle;
			subframe <= '0;
		end
		else
		begin
			case (mode)
				modeIdle:
					if (start)
						mode <= modeWait;
				modeWait:
					if (analysisReady)
					begin
						mode       <= modeRun;
						stepIndex  <= '0;
						firstCycle <= 1'b1;
					end
				modeRun:
				begin
					if (step.kind == finish)
					begin
						mode     <= modeIdle;
						subframe <= '0;
					end
					else if (stepEnd)
					begin
						stepIndex  <= nextIndex;
						firstCycle <= 1'b1;
					end
					else
						firstCycle <= 1'b0;
					if (step.kind == loopInc)
						subframe <= subframe + subfr_t'(subfrLen);  // Next 40 samples
				end
				default:
					mode <= modeIdle;
			endcase
		end
	end

endmodule

// ==== source/encoderControl.sv ====
`timescale 1ns/1ps

module encoderControl (
	input  logic                   clock,
	input  logic                   reset,
	input  logic                   start,
	input  logic                   frameDone,
	input  logic                   divErr,
	input  encCtrlPkg::unitMask_t  unitDone,
	output encCtrlPkg::unitMask_t  unitStart,
	output encCtrlPkg::mathSel_t   mathSel,
	output encCtrlPkg::paramLoad_t paramLoad,
	output logic                   clearParams,
	output logic                   done,
	output encCtrlPkg::subfr_t     subframe
);
	import encCtrlPkg::*;

	logic       analysisReady;
	logic       armed;
	stepIndex_t stepIndex;
	stepDesc_t  step;  // Descriptor of the current step

	frameGate gate0 (
		.clock         (clock),
		.reset         (reset),
		.armed         (armed),
		.frameDone     (frameDone),
		.analysisReady (analysisReady)
	);

	stepTable table0 (
		.stepIndex (stepIndex),
		.step      (step)
	);

	stepSequencer seq0 (
		.clock         (clock),
		.reset         (reset),
		.start         (start),
		.divErr        (divErr),
		.analysisReady (analysisReady),
		.step          (step),
		.unitDone      (unitDone),
		.stepIndex     (stepIndex),
		.armed         (armed),
		.unitStart     (unitStart),
		.mathSel       (mathSel),
		.paramLoad     (paramLoad),
		.clearParams   (clearParams),
		.done          (done),
		.subframe      (subframe)
	);

endmodule

// ==== bench/tbEncoderControl.sv ====
`timescale 1ns/1ps

module tbEncoderControl;
	import encCtrlPkg::*;

	localparam int period          = 40;
	localparam int maxDelay        = 8;                       // Longest unit latency
	localparam int preLoopStarts   = 19;                      // Steps 0 to 18
	localparam int parityBodyStarts = 19;                     // Loop body with parityPitch
	localparam int startsPerFrame  = preLoopStarts + 2 * parityBodyStarts - 1;
	localparam int frameCycleLimit = numSteps * 2 * (maxDelay + 1);
	localparam int watchdogCycles  = 4 * frameCycleLimit + 200;

	localparam paramLoad_t loopIncLoads = '{filterAddr: 1'b1, default: 1'b0};

	typedef struct packed
	{
		unitId_t    unit;
		mathSel_t   mathSel;
		paramLoad_t loads;
		subfr_t     subfr;
	} expect_t;

	logic       clock;
	logic       reset;
	logic       start;
	logic       frameDone;
	logic       divErr;
	unitMask_t  unitDone;
	unitMask_t  unitStart;
	mathSel_t   mathSel;
	paramLoad_t paramLoad;
	logic       clearParams;
	logic       done;
	subfr_t     subframe;

	logic [31:0] lfsrState = 32'hb0e177e3;
	logic [2:0]  delayBits;
	int          pendingCount;
	unitMask_t   pendingMask;
	int          startCount;
	int          doneCount;
	int          errors;
	int          testsRun;
	int          testsFailed;
	int          testErrorBase;
	int          stopCount;
	logic        awaiting;
	logic        loopIncNext;  // Loop increment step follows the math5 done
	paramLoad_t  idleLoads;
	expect_t     curExp;
	expect_t     exp;
	unitId_t     lastUnit;

	encoderControl dut0 (
		.clock       (clock),
		.reset       (reset),
		.start       (start),
		.frameDone   (frameDone),
		.divErr      (divErr),
		.unitDone    (unitDone),
		.unitStart   (unitStart),
		.mathSel     (mathSel),
		.paramLoad   (paramLoad),
		.clearParams (clearParams),
		.done        (done),
		.subframe    (subframe)
	);

	always #(period / 2) clock = ~clock;

	////////////////////////////////////////////////////////////////////////////
	// Reference model of one frame
	////////////////////////////////////////////////////////////////////////////

	// Taps 32, 22, 2, 1
	function automatic logic [31:0] nextLfsr(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	// Unit, math select, loads and subframe of the k-th start in a frame
	function automatic expect_t expectedStep(input int k);
		expect_t e;
		int      b;
		int      s;
		e = '0;
		if (k < preLoopStarts)
			s = k;
		else
		begin
			b = k - preLoopStarts;
			e.subfr = (b < parityBodyStarts) ? subfr_t'(0) : subfr_t'(subfrLen);
			if (b >= parityBodyStarts)
			begin
				b = b - parityBodyStarts;
				if (b >= 11)
					b = b + 1;  // Parity skipped in later subframe
			end
			if (b < 11)
				s = 20 + b;
			else if (b == 11)
				s = 33;
			else if (b < 18)
				s = 35 + (b - 12);
			else
				s = 43;
		end
		if (s <= 18)
			e.mathSel = mathSel_t'(s);
		else if (s <= 30)
			e.mathSel = mathSel_t'(s - 1);
		else if (s == 33)
			e.mathSel = 6'd31;
		else if (s <= 40)
			e.mathSel = mathSel_t'(s - 2);
		else
			e.mathSel = 6'd41;
		case (s)
			9, 10, 13, 14, 20, 21: e.unit = weightAz;
			11, 15, 25, 27:        e.unit = residu;
			12, 16, 23, 24, 26, 28: e.unit = synFilt;
			17: e.unit = pitchOl;
			18: e.unit = math2;
			22: e.unit = math3;
			29: e.unit = pitchFr3;
			30: e.unit = encLag3;
			33: e.unit = parityPitch;
			43: e.unit = math5;
			default: e.unit = (s >= 35) ? unitId_t'(s - 17) : unitId_t'(s);
		endcase
		e.loads.tOp        = (s == 17);
		e.loads.t0Bounds   = (s == 18) || (s == 30);
		e.loads.filterAddr = (s == 18);
		e.loads.iGamma     = (s == 22);
		e.loads.t0         = (s == 29);
		e.loads.index      = (s == 30) || (s == 40);
		e.loads.gainPit    = (s == 37) || (s == 39);
		e.loads.temp       = (s == 38);
		e.loads.lTemp      = (s == 39);
		e.loads.pulseIdx   = (s == 40);
		e.loads.subfr      = (s == 43);
		return e;
	endfunction

	task automatic reportMismatch(input string name, input logic [31:0] got,
		input logic [31:0] want);
		errors++;
		$display("** Error: %s = %h, expected %h (time %0t)", name, got, want, $time);
	endtask

	task automatic reportFailure(input string what);
		errors++;
		$display("Failure at %0t: %s", $time, what);
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Unit models and compare process
	////////////////////////////////////////////////////////////////////////////

	always @(posedge clock)
	begin
		unitDone <= '0;
		if (reset || divErr)
			pendingCount = 0;
		else
		begin
			if (unitStart != '0)
			begin
				pendingMask = unitStart;
				for (int i = 0; i < 3; i++)
				begin
					lfsrState = nextLfsr(lfsrState);
					delayBits = {delayBits[1:0], lfsrState[0]};
				end
				pendingCount = delayBits + 1;  // 1 to 8 cycles
			end
			if (pendingCount > 0)
			begin
				pendingCount = pendingCount - 1;
				if (pendingCount == 0)
					unitDone <= pendingMask;
			end
		end
	end

	always @(posedge clock)
	begin
		if (reset || divErr)
		begin
			awaiting    = 1'b0;
			loopIncNext = 1'b0;
		end
		else
		begin
			if (unitStart != '0)
			begin
				exp = expectedStep(startCount);
				assert ((unitStart & (unitStart - 1'b1)) == '0)
					else reportFailure("start pulse has more than one bit set");
				assert (unitStart == (unitMask_t'(1) << exp.unit))
					else reportMismatch("unitStart", unitStart, unitMask_t'(1) << exp.unit);
				assert (mathSel == exp.mathSel)
					else reportMismatch("mathSel", mathSel, exp.mathSel);
				assert (subframe == exp.subfr)
					else reportMismatch("subframe", subframe, exp.subfr);
				assert (doneCount == 0)
					else reportFailure("a unit started after done");
				curExp   = exp;
				awaiting = 1'b1;
				startCount++;
			end
			else if (awaiting)
			begin
				assert (mathSel == curExp.mathSel)
					else reportMismatch("mathSel", mathSel, curExp.mathSel);
				if (unitDone[curExp.unit])
				begin
					assert (paramLoad == curExp.loads)
						else reportMismatch("paramLoad", paramLoad, curExp.loads);
					awaiting    = 1'b0;
					lastUnit    = curExp.unit;
					loopIncNext = (curExp.unit == math5);
				end
			end
			else
			begin
				idleLoads   = loopIncNext ? loopIncLoads : '0;
				loopIncNext = 1'b0;
				assert (paramLoad == idleLoads)
					else reportMismatch("paramLoad", paramLoad, idleLoads);
			end
			if (done)
			begin
				doneCount++;
				assert (lastUnit == math5 && startCount == startsPerFrame)
					else reportFailure("done pulsed before the second math5 finished");
			end
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Tests
	////////////////////////////////////////////////////////////////////////////

	task automatic armAndSendFrames();
		startCount = 0;
		doneCount  = 0;
		@(posedge clock);
		start <= 1'b1;
		@(posedge clock);
		start <= 1'b0;
		assert (clearParams == 1'b0)
			else reportMismatch("clearParams", clearParams, 0);
		repeat (4) @(posedge clock);
		frameDone <= 1'b1;
		@(posedge clock);
		frameDone <= 1'b0;
		repeat (6) @(posedge clock);
		assert (startCount == 0)
			else reportFailure("a unit started before the second frame arrived");
		frameDone <= 1'b1;
		@(posedge clock);
		frameDone <= 1'b0;
	endtask

	task automatic runFrame();
		int waited;
		armAndSendFrames();
		waited = 0;
		while (doneCount == 0 && waited < frameCycleLimit)
		begin
			@(posedge clock);
			waited++;
		end
		assert (doneCount != 0) else reportFailure("done never pulsed");
		repeat (20) @(posedge clock);
		assert (startCount == startsPerFrame)
			else reportMismatch("startCount", startCount, startsPerFrame);
		assert (doneCount == 1) else reportMismatch("doneCount", doneCount, 1);
		assert (subframe == '0) else reportMismatch("subframe", subframe, 0);
	endtask

	task automatic endTest(input string name);
		testsRun++;
		if (errors != testErrorBase)
			testsFailed++;
		$display("Test %0d %s: %0d errors", testsRun, name, errors - testErrorBase);
		testErrorBase = errors;
	endtask

	initial
	begin
		clock     = 1'b0;
		reset     = 1'b1;
		start     = 1'b0;
		frameDone = 1'b0;
		divErr    = 1'b0;
		unitDone  = '0;
		repeat (3) @(posedge clock);
		reset <= 1'b0;
		repeat (2) @(posedge clock);
		assert (unitStart == '0) else reportMismatch("unitStart", unitStart, 0);
		assert (paramLoad == '0) else reportMismatch("paramLoad", paramLoad, 0);
		assert (done == 1'b0) else reportMismatch("done", done, 0);
		assert (clearParams == 1'b1) else reportMismatch("clearParams", clearParams, 1);
		assert (mathSel == '0) else reportMismatch("mathSel", mathSel, 0);
		assert (subframe == '0) else reportMismatch("subframe", subframe, 0);
		endTest("reset state");

		runFrame();
		endTest("full frame");

		armAndSendFrames();
		while (startCount < 25)
			@(posedge clock);
		divErr <= 1'b1;
		@(posedge clock);
		divErr <= 1'b0;
		@(posedge clock);
		stopCount = startCount;
		repeat (30) @(posedge clock);
		assert (startCount == stopCount) else reportFailure("a unit started after the abort");
		assert (doneCount == 0) else reportFailure("done pulsed after the abort");
		assert (clearParams == 1'b1) else reportMismatch("clearParams", clearParams, 1);
		endTest("division error abort");

		runFrame();
		endTest("frame after abort");

		$display("%0d tests, %0d failed, %0d errors", testsRun, testsFailed, errors);
		if (errors == 0)
			$display("=== PASS ===");
		else
			$display("=== FAIL ===");
		$finish;
	end

	// Bound on the whole run
	initial
	begin
		#(watchdogCycles * period);
		$display("Watchdog expired before the tests finished");
		$display("=== FAIL ===");
		$finish;
	end

endmodule

// ==== tb.f ====
source/encCtrlPkg.sv
source/frameGate.sv
source/stepTable.sv
source/stepSequencer.sv
source/encoderControl.sv
bench/tbEncoderControl.sv

// ==== Bender.yml ====
package:
  name: encoder_control

sources:
  - source/encCtrlPkg.sv
  - source/frameGate.sv
  - source/stepTable.sv
  - source/stepSequencer.sv
  - source/encoderControl.sv
  - target: test
    files:
      - bench/tbEncoderControl.sv
